// File: hdl/board_pkg.sv
`default_nettype none

package board_pkg;

  // reset stretch length, also the stretcher register width
  localparam int RESET_STRETCH = 32;

  localparam int NUM_BTNS = 7;

  localparam int NUM_INIT_CMDS = 4;
  localparam int INIT_IDX_W = $clog2(NUM_INIT_CMDS);

  // panel init: display on, remap, column range, row range
  localparam logic [7:0] OLED_INIT_CMDS [NUM_INIT_CMDS] = '{8'hAF, 8'hA0, 8'h15, 8'h75};

  // oled_resn low time after core reset ends
  localparam int OLED_RESN_CYCLES = 8;
  localparam int RESN_CNT_W = $clog2(OLED_RESN_CYCLES);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    SHIFT,
    HOLD
  } spi_state_t;

  typedef enum logic [2:0] {
    PANEL_RESET,
    INIT,
    WAIT_CHANGE,
    DATA_HI,
    DATA_LO
  } seq_state_t;

  // dc is 0 for a command, 1 for data
  typedef struct packed {
    logic       dc;
    logic [7:0] data;
  } oled_byte_t;

  typedef struct packed {
    logic inc;
    logic dec;
    logic clr;
  } btn_pulse_t;

endpackage

`default_nettype wire

// File: hdl/reset_stretcher.sv
`timescale 1ns/1ps
`default_nettype none

module reset_stretcher import board_pkg::*; (
  input  logic clk_25mhz,
  input  logic rst_n,
  input  logic ready,
  output logic core_reset
);

  logic [RESET_STRETCH-1:0] stretch_q;

  // ones while not ready, then zeros walk in from the top
  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      stretch_q <= '1;
    end else if (!ready) begin
      stretch_q <= '1;
    end else begin
      stretch_q <= stretch_q >> 1;
    end
  end

  assign core_reset = stretch_q[0];

endmodule

`default_nettype wire

// File: hdl/button_sync.sv
`timescale 1ns/1ps
`default_nettype none

module button_sync import board_pkg::*; (
  input  logic                clk_25mhz,
  input  logic                rst_n,
  input  logic [NUM_BTNS-1:0] btns,
  output btn_pulse_t          pulses
);

  // buttons 1 to 3 only
  logic [2:0] sync1_q;
  logic [2:0] sync2_q;
  logic [2:0] prev_q;
  logic [2:0] pulse_q;

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      pulse_q <= '0;
    end else begin
      sync1_q <= btns[3:1];
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // registered edge, so the pulse lands 3 cycles after the pin
      pulse_q <= sync2_q & ~prev_q;
    end
  end

  assign pulses.inc = pulse_q[0];
  assign pulses.dec = pulse_q[1];
  assign pulses.clr = pulse_q[2];

endmodule

`default_nettype wire

// File: hdl/oled_spi.sv
`timescale 1ns/1ps
`default_nettype none

module oled_spi import board_pkg::*; (
  input  logic       clk_25mhz,
  input  logic       rst_n,
  input  logic       start,
  input  oled_byte_t tx_byte,
  output logic       busy,
  output logic       done,
  output logic       oled_clk,
  output logic       oled_mosi,
  output logic       oled_dc,
  output logic       oled_csn
);

  spi_state_t state_q;
  logic [2:0] bit_q;
  logic       phase_q;
  logic [7:0] shift_q;
  logic       dc_q;
  logic       done_q;
  logic       accept;

  assign accept = (state_q == IDLE) && start;

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      bit_q   <= '0;
      phase_q <= 1'b0;
      dc_q    <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q <= SETUP;
            bit_q   <= '0;
            phase_q <= 1'b0;
            dc_q    <= tx_byte.dc;
          end
        end
        SETUP: begin
          state_q <= SHIFT;
        end
        SHIFT: begin
          // phase 0 is clk low, phase 1 is clk high
          phase_q <= ~phase_q;
          if (phase_q) begin
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) begin
              state_q <= HOLD;
            end
          end
        end
        HOLD: begin
          state_q <= IDLE;
          done_q  <= 1'b1;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // msb first, next bit appears as clk falls
  always_ff @(posedge clk_25mhz) begin
    if (accept) begin
      shift_q <= tx_byte.data;
    end else if (state_q == SHIFT && phase_q) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign busy      = (state_q != IDLE);
  assign done      = done_q;
  assign oled_csn  = (state_q == IDLE);
  assign oled_clk  = (state_q == SHIFT) && phase_q;
  assign oled_mosi = (state_q != IDLE) && shift_q[7];
  assign oled_dc   = dc_q;

endmodule

`default_nettype wire

// File: hdl/oled_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module oled_sequencer import board_pkg::*; (
  input  logic       clk_25mhz,
  input  logic       rst_n,
  input  logic       core_reset,
  input  logic [7:0] value,
  output logic       start,
  output oled_byte_t tx_byte,
  input  logic       busy,
  input  logic       done,
  output logic       oled_resn
);

  seq_state_t            state_q;
  logic [RESN_CNT_W-1:0] resn_cnt_q;
  logic [INIT_IDX_W-1:0] init_idx_q;
  logic [7:0]            last_sent_q;
  logic [7:0]            frame_q;
  logic                  issued_q;
  logic                  start_q;
  logic                  resn_q;
  oled_byte_t            tx_q;
  oled_byte_t            next_byte;
  logic                  sending;
  logic                  issue;

  assign sending = (state_q == INIT) || (state_q == DATA_HI) || (state_q == DATA_LO);
  // one byte in flight at a time
  assign issue   = sending && !issued_q && !busy;

  always_comb begin
    case (state_q)
      DATA_HI: next_byte = '{dc: 1'b1, data: frame_q};
      DATA_LO: next_byte = '{dc: 1'b1, data: ~frame_q};
      default: next_byte = '{dc: 1'b0, data: OLED_INIT_CMDS[init_idx_q]};
    endcase
  end

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= PANEL_RESET;
      resn_cnt_q  <= '0;
      init_idx_q  <= '0;
      last_sent_q <= '0;
      issued_q    <= 1'b0;
      start_q     <= 1'b0;
      resn_q      <= 1'b0;
    end else if (core_reset) begin
      state_q     <= PANEL_RESET;
      resn_cnt_q  <= '0;
      init_idx_q  <= '0;
      last_sent_q <= '0;
      issued_q    <= 1'b0;
      start_q     <= 1'b0;
      resn_q      <= 1'b0;
    end else begin
      start_q <= issue;
      if (issue) begin
        issued_q <= 1'b1;
      end
      case (state_q)
        PANEL_RESET: begin
          resn_cnt_q <= resn_cnt_q + 1'b1;
          if (resn_cnt_q == RESN_CNT_W'(OLED_RESN_CYCLES - 1)) begin
            resn_q  <= 1'b1;
            state_q <= INIT;
          end
        end
        INIT: begin
          if (done) begin
            issued_q <= 1'b0;
            if (init_idx_q == INIT_IDX_W'(NUM_INIT_CMDS - 1)) begin
              state_q <= WAIT_CHANGE;
            end else begin
              init_idx_q <= init_idx_q + 1'b1;
            end
          end
        end
        WAIT_CHANGE: begin
          if (value != last_sent_q) begin
            state_q <= DATA_HI;
          end
        end
        DATA_HI: begin
          if (done) begin
            issued_q <= 1'b0;
            state_q  <= DATA_LO;
          end
        end
        DATA_LO: begin
          if (done) begin
            issued_q    <= 1'b0;
            last_sent_q <= frame_q;
            state_q     <= WAIT_CHANGE;
          end
        end
        default: begin
          state_q <= PANEL_RESET;
        end
      endcase
    end
  end

  // frame value is frozen for both bytes
  always_ff @(posedge clk_25mhz) begin
    if (state_q == WAIT_CHANGE && value != last_sent_q) begin
      frame_q <= value;
    end
    if (issue) begin
      tx_q <= next_byte;
    end
  end

  assign start     = start_q;
  assign tx_byte   = tx_q;
  assign oled_resn = resn_q;

endmodule

`default_nettype wire

// File: hdl/main.sv
`timescale 1ns/1ps
`default_nettype none

module main import board_pkg::*; (
  input  logic                clk_25mhz,
  input  logic                rst_n,
  input  logic                core_reset,
  input  logic [NUM_BTNS-1:0] btns,
  output logic [7:0]          leds,
  output logic                oled_clk,
  output logic                oled_mosi,
  output logic                oled_dc,
  output logic                oled_resn,
  output logic                oled_csn
);

  btn_pulse_t pulses;
  oled_byte_t tx_byte;
  logic [7:0] count_q;
  logic       start;
  logic       busy;
  logic       done;

  button_sync i_button_sync (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .btns      (btns),
    .pulses    (pulses)
  );

  // clr over inc over dec
  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (core_reset) begin
      count_q <= '0;
    end else if (pulses.clr) begin
      count_q <= '0;
    end else if (pulses.inc) begin
      count_q <= count_q + 8'd1;
    end else if (pulses.dec) begin
      count_q <= count_q - 8'd1;
    end
  end

  assign leds = count_q;

  oled_sequencer i_oled_sequencer (
    .clk_25mhz  (clk_25mhz),
    .rst_n      (rst_n),
    .core_reset (core_reset),
    .value      (count_q),
    .start      (start),
    .tx_byte    (tx_byte),
    .busy       (busy),
    .done       (done),
    .oled_resn  (oled_resn)
  );

  oled_spi i_oled_spi (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .start     (start),
    .tx_byte   (tx_byte),
    .busy      (busy),
    .done      (done),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi),
    .oled_dc   (oled_dc),
    .oled_csn  (oled_csn)
  );

endmodule

`default_nettype wire

// File: hdl/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top import board_pkg::*; (
  input  logic                clk_25mhz,
  input  logic                rst_n,
  input  logic [NUM_BTNS-1:0] btns,
  output logic [7:0]          leds,
  output logic                oled_clk,
  output logic                oled_mosi,
  output logic                oled_dc,
  output logic                oled_resn,
  output logic                oled_csn
);

  logic core_reset;

  // button 0 is the run/ready level
  reset_stretcher i_reset_stretcher (
    .clk_25mhz  (clk_25mhz),
    .rst_n      (rst_n),
    .ready      (btns[0]),
    .core_reset (core_reset)
  );

  main i_main (
    .clk_25mhz  (clk_25mhz),
    .rst_n      (rst_n),
    .core_reset (core_reset),
    .btns       (btns),
    .leds       (leds),
    .oled_clk   (oled_clk),
    .oled_mosi  (oled_mosi),
    .oled_dc    (oled_dc),
    .oled_resn  (oled_resn),
    .oled_csn   (oled_csn)
  );

endmodule

`default_nettype wire

// File: tests/board_top_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module board_top_assertions (
  input logic clk_25mhz,
  input logic rst_n,
  input logic start,
  input logic busy,
  input logic done,
  input logic oled_clk,
  input logic oled_dc,
  input logic oled_csn
);

  // clock parks low outside a byte
  clk_low_when_idle: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    oled_csn |-> !oled_clk)
    else $error("oled_clk high while oled_csn is high");

  dc_stable_in_byte: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    (!oled_csn && !$past(oled_csn)) |-> $stable(oled_dc))
    else $error("oled_dc changed while oled_csn is low");

  start_only_when_idle: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    start |-> !busy)
    else $error("start given while busy");

  done_single_cycle: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    done |=> !done)
    else $error("done held longer than one cycle");

endmodule

bind oled_spi board_top_assertions i_spi_assertions (
  .clk_25mhz (clk_25mhz),
  .rst_n     (rst_n),
  .start     (start),
  .busy      (busy),
  .done      (done),
  .oled_clk  (oled_clk),
  .oled_dc   (oled_dc),
  .oled_csn  (oled_csn)
);

`default_nettype wire

// File: tests/board_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_top_tb import board_pkg::*; ();

  logic                clk_25mhz = 1'b0;
  logic                rst_n;
  logic [NUM_BTNS-1:0] btns;
  logic [7:0]          leds;
  logic                oled_clk;
  logic                oled_mosi;
  logic                oled_dc;
  logic                oled_resn;
  logic                oled_csn;

  logic [7:0] vec_mem [0:127];
  logic [8:0] rx_q [$];
  logic [8:0] exp_q [$];
  logic [7:0] rx_shift = 8'h00;
  int         bit_cnt = 0;
  int         clk_edges = 0;
  int         error_count = 0;
  int         fault_count = 0;
  integer     seed;

  board_top i_board_top (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .btns      (btns),
    .leds      (leds),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi),
    .oled_dc   (oled_dc),
    .oled_resn (oled_resn),
    .oled_csn  (oled_csn)
  );

  always #20 clk_25mhz = ~clk_25mhz;

  // spi receiver, one entry per byte as {dc, data}
  always @(posedge oled_clk) begin
    clk_edges = clk_edges + 1;
    rx_shift = {rx_shift[6:0], oled_mosi};
    bit_cnt = bit_cnt + 1;
    if (bit_cnt == 8) begin
      rx_q.push_back({oled_dc, rx_shift});
      bit_cnt = 0;
    end
  end

  task automatic step(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_25mhz);
      #2;
    end
  endtask

  task automatic value_error(input string msg);
    error_count++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic fault(input string msg);
    fault_count++;
    $display("fault at %0t ns: %s", $time, msg);
  endtask

  task automatic check_hold(input int n);
    int edges_before;
    edges_before = clk_edges;
    for (int i = 0; i < n; i++) begin
      step(1);
      if (leds !== 8'h00) begin
        value_error($sformatf("leds %02h during reset hold, expected 00", leds));
      end
      if (oled_csn !== 1'b1) begin
        value_error("oled_csn low during reset hold");
      end
      if (oled_resn !== 1'b0) begin
        value_error("oled_resn high during reset hold");
      end
    end
    if (clk_edges != edges_before) begin
      value_error("oled_clk toggled during reset hold");
    end
  endtask

  task automatic wait_resn(input int limit);
    int cycles;
    cycles = 0;
    while (oled_resn !== 1'b1 && cycles < limit) begin
      step(1);
      cycles++;
    end
    if (oled_resn !== 1'b1) begin
      fault("oled_resn never went high after ready rose");
    end
  endtask

  task automatic wait_leds(input logic [7:0] want, input int limit);
    int cycles;
    cycles = 0;
    while (leds !== want && cycles < limit) begin
      step(1);
      cycles++;
    end
    if (leds !== want) begin
      value_error($sformatf("leds %02h, expected %02h", leds, want));
    end
  endtask

  // waits for every queued expected byte, then compares in order
  task automatic check_bytes(input string what);
    int         cycles;
    int         n;
    logic [8:0] got;
    logic [8:0] want;
    cycles = 0;
    n = 0;
    while (rx_q.size() < exp_q.size() && cycles < 30 * exp_q.size() + 20) begin
      step(1);
      cycles++;
    end
    if (rx_q.size() < exp_q.size()) begin
      fault($sformatf("%s: only %0d of %0d bytes arrived", what, rx_q.size(), exp_q.size()));
    end
    while (exp_q.size() > 0 && rx_q.size() > 0) begin
      got = rx_q.pop_front();
      want = exp_q.pop_front();
      if (got !== want) begin
        value_error($sformatf("%s byte %0d: got dc %0b data %02h, expected dc %0b data %02h",
                              what, n, got[8], got[7:0], want[8], want[7:0]));
      end
      n++;
    end
    exp_q.delete();
  endtask

  task automatic expect_init();
    for (int i = 0; i < NUM_INIT_CMDS; i++) begin
      exp_q.push_back({1'b0, OLED_INIT_CMDS[i]});
    end
    check_bytes("init");
  endtask

  task automatic press(input int idx);
    btns[idx] = 1'b1;
    step(3);
    btns[idx] = 1'b0;
  endtask

  initial begin
    int         idx;
    int         gap;
    logic [7:0] btn;
    logic [7:0] prev_leds;
    logic       quick;
    seed = 32'hbb3c_4437;
    rst_n = 1'b0;
    btns = '0;
    for (int i = 0; i < 128; i++) begin
      vec_mem[i] = 8'hff;
    end
    $readmemh("tests/oled_vectors.txt", vec_mem);
    if (vec_mem[0] === 8'hff) begin
      fault("no vectors read from tests/oled_vectors.txt");
    end
    step(5);
    rst_n = 1'b1;
    check_hold(10);
    btns[0] = 1'b1;
    wait_resn(RESET_STRETCH + OLED_RESN_CYCLES + 20);
    expect_init();
    prev_leds = 8'h00;
    quick = 1'b0;
    idx = 0;
    while (idx < 124 && vec_mem[idx] !== 8'hff) begin
      btn = vec_mem[idx];
      if (!quick && rx_q.size() != 0) begin
        value_error($sformatf("%0d unexpected bytes before vector %0d", rx_q.size(), idx / 4));
        rx_q.delete();
      end
      if (btn == 8'h00) begin
        // ready drop mid-run
        btns[0] = 1'b0;
        step(3);
        check_hold(10);
        btns[0] = 1'b1;
        wait_resn(RESET_STRETCH + OLED_RESN_CYCLES + 20);
        expect_init();
      end else begin
        press(int'(btn[3:0]));
        wait_leds(vec_mem[idx + 1], 20);
        if (vec_mem[idx + 1] != prev_leds) begin
          exp_q.push_back({1'b1, vec_mem[idx + 2]});
          exp_q.push_back({1'b1, vec_mem[idx + 3]});
        end
        if (!btn[4]) begin
          check_bytes($sformatf("frame of vector %0d", idx / 4));
        end
      end
      prev_leds = vec_mem[idx + 1];
      quick = btn[4];
      if (quick) begin
        step(4);
      end else begin
        gap = $unsigned($random(seed)) % 21;
        step(100 + gap);
      end
      idx += 4;
    end
    step(50);
    if (rx_q.size() != 0) begin
      value_error($sformatf("%0d unexpected bytes at end of run", rx_q.size()));
    end
    $display("wrong values: %0d, timeouts or other faults: %0d", error_count, fault_count);
    if (error_count == 0 && fault_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/oled_vectors.txt
// columns (hex): button, expected leds, expected frame byte 0, expected frame byte 1
// button 0 drops ready; bit 4 set means the next press comes inside the same frame time
1 01 01 fe
1 02 02 fd
2 01 01 fe
2 00 00 ff
2 ff ff 00
2 fe fe 01
1 ff ff 00
1 00 00 ff
1 01 01 fe
3 00 00 ff
1 01 01 fe
1 02 02 fd
11 03 03 fc
1 04 04 fb
1 05 05 fa
0 00 00 00
1 01 01 fe
2 00 00 ff
ff ff ff ff

// File: project.f
hdl/board_pkg.sv
hdl/reset_stretcher.sv
hdl/button_sync.sv
hdl/oled_spi.sv
hdl/oled_sequencer.sv
hdl/main.sv
hdl/board_top.sv
tests/board_top_assertions.sv
tests/board_top_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module board_top_tb -o board_top_sim

out=$(./obj_dir/board_top_sim) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
  exit 0
else
  exit 1
fi
